// File: hdl/sd_pkg.sv
package sd_pkg;

    // phase of the timing word.
    // the five pulse phases come first, in firing order, so the
    // sequencer can step through them by adding one.
    typedef enum logic [2:0] {
        ph_v1   = 3'd0,
        ph_w2   = 3'd1,
        ph_x1   = 3'd2,
        ph_y7   = 3'd3,
        ph_z2   = 3'd4,
        ph_idle = 3'd5
    } sd_phase_t;

    // number of pulse phases in one timing word.
    parameter int phase_count = 5;

    // reset levels for the clocked inverter.
    // the ml side of a memory-load cell comes out of reset low and
    // its complement comes out high.
    parameter logic inv_reset_high = 1'b1;
    parameter logic inv_reset_low  = 1'b0;

endpackage

// File: hdl/sd_gates.sv
`timescale 1ns/10ps

// inverting receiver with one cycle of delay.
module dia (
    output logic y,
    input  logic a,
    input  logic sim_clk,
    input  logic rst
);

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            y <= 1'b1;
        end else begin
            y <= ~a;
        end
    end

endmodule

// slower timing-strobe receiver, two register stages deep.
module dib (
    output logic y,
    input  logic a,
    input  logic sim_clk,
    input  logic rst
);

    logic a_q;

    // first stage holds the raw level, second stage inverts it.
    always_ff @(posedge sim_clk) begin
        if (rst) begin
            a_q <= 1'b0;
            y   <= 1'b1;
        end else begin
            a_q <= a;
            y   <= ~a_q;
        end
    end

endmodule

// clocked inverter with a selectable reset level.
module inv #(
    parameter logic init = sd_pkg::inv_reset_high
) (
    output logic y,
    input  logic a,
    input  logic sim_clk,
    input  logic rst
);

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            y <= init;
        end else begin
            y <= ~a;
        end
    end

endmodule

// File: hdl/sd_timing_gen.sv
`timescale 1ns/10ps

module sd_timing_gen #(
    parameter int unsigned idle_cycles = 2
) (
    input  logic sim_clk,
    input  logic rst,
    output logic v1,
    output logic w2,
    output logic x1,
    output logic y7,
    output logic z2
);

    localparam int cnt_w = (idle_cycles > 1) ? $clog2(idle_cycles) : 1;
    localparam logic [cnt_w-1:0] idle_last = cnt_w'(idle_cycles - 1);

    // last pulse phase before the idle gap.
    localparam sd_pkg::sd_phase_t last_phase =
        sd_pkg::sd_phase_t'(sd_pkg::phase_count - 1);

    sd_pkg::sd_phase_t state;
    logic [cnt_w-1:0]  idle_cnt;

    // pulses are decoded from the state and registered, so each
    // one is high for exactly one cycle and never overlaps another.
    always_ff @(posedge sim_clk) begin
        if (rst) begin
            state    <= sd_pkg::ph_v1;
            idle_cnt <= '0;
            v1       <= 1'b0;
            w2       <= 1'b0;
            x1       <= 1'b0;
            y7       <= 1'b0;
            z2       <= 1'b0;
        end else begin
            v1 <= (state == sd_pkg::ph_v1);
            w2 <= (state == sd_pkg::ph_w2);
            x1 <= (state == sd_pkg::ph_x1);
            y7 <= (state == sd_pkg::ph_y7);
            z2 <= (state == sd_pkg::ph_z2);

            if (state == sd_pkg::ph_idle) begin
                // all pulses low for idle_cycles cycles.
                if (idle_cnt == idle_last) begin
                    state    <= sd_pkg::ph_v1;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end else if (state == last_phase) begin
                // with no gap the word restarts straight away.
                state <= (idle_cycles == 0) ? sd_pkg::ph_v1 : sd_pkg::ph_idle;
            end else begin
                state <= sd_pkg::sd_phase_t'(state + 3'd1);
            end
        end
    end

endmodule

// File: hdl/sd_sampler_7.sv
`timescale 1ns/10ps

module sd_sampler_7 (
    input  logic sim_clk,
    input  logic rst,

    input  logic v1,
    input  logic w2,
    input  logic x1,
    input  logic y7,
    input  logic z2,

    input  logic c4rdn,
    input  logic cr13,
    input  logic cr14,
    input  logic crcav,
    input  logic diad,
    input  logic din9,
    input  logic din10,
    input  logic din23,
    input  logic din24,
    input  logic dis7,
    input  logic dis8,
    input  logic disa,
    input  logic g5dvn,
    input  logic g6dv,
    input  logic g6dvn,
    input  logic g7dv,
    input  logic gc13,
    input  logic gc14,
    input  logic icsd,
    input  logic icsdn,
    input  logic mlav,
    input  logic paav,
    input  logic pbg2v,
    input  logic pcg2v,
    input  logic resmv,
    input  logic ssa,
    input  logic ssfb1,
    input  logic tsa,

    input  logic ts9,
    input  logic ts10,

    output logic ml13,
    output logic ml14
);

    logic din9_n;
    logic din10_n;
    logic din23_n;
    logic din24_n;
    logic cr13_n;
    logic cr14_n;
    logic gc13_n;
    logic gc14_n;
    logic dis7_n;
    logic dis8_n;
    logic ssfb1_n;
    logic ts9_n;
    logic ts10_n;

    logic ml13_n;
    logic ml14_n;
    logic s13;
    logic s14;
    logic c13;
    logic c14;

    // bit 13 receivers.
    dia a3a  (.y(din9_n),  .a(din9),  .sim_clk(sim_clk), .rst(rst));
    dia a7a  (.y(cr13_n),  .a(cr13),  .sim_clk(sim_clk), .rst(rst));
    dia a21a (.y(gc13_n),  .a(gc13),  .sim_clk(sim_clk), .rst(rst));
    dia a2a  (.y(din23_n), .a(din23), .sim_clk(sim_clk), .rst(rst));
    dia a1a  (.y(dis7_n),  .a(dis7),  .sim_clk(sim_clk), .rst(rst));
    dib a15a (.y(ts9_n),   .a(ts9),   .sim_clk(sim_clk), .rst(rst));

    // bit 14 receivers, plus the ss feedback line.
    dia a3b  (.y(din10_n), .a(din10), .sim_clk(sim_clk), .rst(rst));
    dia a7b  (.y(cr14_n),  .a(cr14),  .sim_clk(sim_clk), .rst(rst));
    dia a14a (.y(ssfb1_n), .a(ssfb1), .sim_clk(sim_clk), .rst(rst));
    dia a21b (.y(gc14_n),  .a(gc14),  .sim_clk(sim_clk), .rst(rst));
    dia a2b  (.y(din24_n), .a(din24), .sim_clk(sim_clk), .rst(rst));
    dia a1b  (.y(dis8_n),  .a(dis8),  .sim_clk(sim_clk), .rst(rst));
    dib a15b (.y(ts10_n),  .a(ts10),  .sim_clk(sim_clk), .rst(rst));

    // set network for bit 13, one product per load path.
    assign s13 = (y7 & din9_n & pbg2v & diad)
               | (y7 & ~g6dv & c4rdn & paav & g5dvn)
               | (x1 & cr13_n & icsd & pcg2v & crcav)
               | (x1 & gc13_n & crcav & pcg2v & icsdn)
               | (x1 & din23_n & diad & pcg2v)
               | (w2 & dis7_n & pcg2v & disa)
               | (w2 & pcg2v & ts9_n & tsa)
               | (v1 & ml13_n);

    // clear network, also the hold for a set bit's complement.
    assign c13 = (v1 & ml13) | (z2 & resmv & mlav);

    // bit 14 carries the extra ss term.
    assign s14 = (y7 & din10_n & pbg2v & diad)
               | (y7 & ~g7dv & c4rdn & paav & g6dvn)
               | (y7 & ssfb1_n & ssa & pbg2v)
               | (x1 & cr14_n & icsd & pcg2v & crcav)
               | (x1 & gc14_n & crcav & pcg2v & icsdn)
               | (x1 & din24_n & diad & pcg2v)
               | (w2 & dis8_n & pcg2v & disa)
               | (w2 & pcg2v & ts10_n & tsa)
               | (v1 & ml14_n);

    assign c14 = (v1 & ml14) | (z2 & resmv & mlav);

    // cross-coupled memory-load cells.
    inv #(.init(sd_pkg::inv_reset_low)) a25c (
        .y(ml13), .a(s13), .sim_clk(sim_clk), .rst(rst)
    );
    inv #(.init(sd_pkg::inv_reset_high)) a24c (
        .y(ml13_n), .a(c13), .sim_clk(sim_clk), .rst(rst)
    );
    inv #(.init(sd_pkg::inv_reset_low)) a25f (
        .y(ml14), .a(s14), .sim_clk(sim_clk), .rst(rst)
    );
    inv #(.init(sd_pkg::inv_reset_high)) a24f (
        .y(ml14_n), .a(c14), .sim_clk(sim_clk), .rst(rst)
    );

endmodule

// File: hdl/sd_sampler.sv
`timescale 1ns/10ps

module sd_sampler #(
    parameter int unsigned idle_cycles = 2
) (
    input  logic sim_clk,
    input  logic rst,

    input  logic c4rdn,
    input  logic cr13,
    input  logic cr14,
    input  logic crcav,
    input  logic diad,
    input  logic din9,
    input  logic din10,
    input  logic din23,
    input  logic din24,
    input  logic dis7,
    input  logic dis8,
    input  logic disa,
    input  logic g5dvn,
    input  logic g6dv,
    input  logic g6dvn,
    input  logic g7dv,
    input  logic gc13,
    input  logic gc14,
    input  logic icsd,
    input  logic icsdn,
    input  logic mlav,
    input  logic paav,
    input  logic pbg2v,
    input  logic pcg2v,
    input  logic resmv,
    input  logic ssa,
    input  logic ssfb1,
    input  logic tsa,
    input  logic ts9,
    input  logic ts10,

    output logic ml13,
    output logic ml14
);

    logic v1;
    logic w2;
    logic x1;
    logic y7;
    logic z2;

    sd_timing_gen #(
        .idle_cycles(idle_cycles)
    ) u_timing (
        .sim_clk (sim_clk),
        .rst     (rst),
        .v1      (v1),
        .w2      (w2),
        .x1      (x1),
        .y7      (y7),
        .z2      (z2)
    );

    // the slice sees the phase pulses one cycle after they are decoded.
    sd_sampler_7 u_slice (
        .sim_clk (sim_clk),
        .rst     (rst),
        .v1      (v1),
        .w2      (w2),
        .x1      (x1),
        .y7      (y7),
        .z2      (z2),
        .c4rdn   (c4rdn),
        .cr13    (cr13),
        .cr14    (cr14),
        .crcav   (crcav),
        .diad    (diad),
        .din9    (din9),
        .din10   (din10),
        .din23   (din23),
        .din24   (din24),
        .dis7    (dis7),
        .dis8    (dis8),
        .disa    (disa),
        .g5dvn   (g5dvn),
        .g6dv    (g6dv),
        .g6dvn   (g6dvn),
        .g7dv    (g7dv),
        .gc13    (gc13),
        .gc14    (gc14),
        .icsd    (icsd),
        .icsdn   (icsdn),
        .mlav    (mlav),
        .paav    (paav),
        .pbg2v   (pbg2v),
        .pcg2v   (pcg2v),
        .resmv   (resmv),
        .ssa     (ssa),
        .ssfb1   (ssfb1),
        .tsa     (tsa),
        .ts9     (ts9),
        .ts10    (ts10),
        .ml13    (ml13),
        .ml14    (ml14)
    );

endmodule

// File: tb/sd_sampler_tb.sv
`timescale 1ns/10ps

module sd_sampler_tb;

    localparam int idle_cycles = 2;
    localparam int word_len = sd_pkg::phase_count + idle_cycles;

    logic sim_clk;
    logic rst;
    logic c4rdn, crcav, diad, disa, g5dvn, g6dv, g6dvn, g7dv, icsd;
    logic icsdn, mlav, paav, pbg2v, pcg2v, resmv, ssa, tsa;
    logic din9, din10, din23, din24, cr13, cr14, gc13, gc14;
    logic dis7, dis8, ssfb1, ts9, ts10;
    logic ml13;
    logic ml14;

    // cycle model state.
    logic m_v1, m_w2, m_x1, m_y7, m_z2;
    logic n_din9, n_din10, n_din23, n_din24, n_cr13, n_cr14;
    logic n_gc13, n_gc14, n_dis7, n_dis8, n_ssfb1;
    logic ts9_d, ts10_d, n_ts9, n_ts10;
    logic m_ml13, m_ml13_n, m_ml14, m_ml14_n;
    logic model_valid;
    int   edge_cnt;

    // stimulus table.
    logic [12:0] row_lo[$];
    logic [16:0] row_en[$];
    int          row_hold[$];
    int          n_directed;
    int          total_cycles;
    logic [15:0] lfsr_state;

    int errors;
    int checks;
    int timeouts;

    sd_sampler #(.idle_cycles(idle_cycles)) dut (.*);

    initial sim_clk = 1'b0;
    always #5 sim_clk = ~sim_clk;

    // taps of x^16 + x^14 + x^13 + x^11 + 1 with the shift toward the msb.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[15]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic add_row(input int hold, input logic [12:0] lo, input logic [16:0] en);
        row_hold.push_back(hold);
        row_lo.push_back(lo);
        row_en.push_back(en);
        total_cycles += hold;
    endtask

    task automatic drive_row(input logic [12:0] lo, input logic [16:0] en);
        {din9, din10, din23, din24, cr13, cr14, gc13, gc14,
         dis7, dis8, ssfb1, ts9, ts10} = lo;
        {c4rdn, crcav, diad, disa, g5dvn, g6dv, g6dvn, g7dv, icsd,
         icsdn, mlav, paav, pbg2v, pcg2v, resmv, ssa, tsa} = en;
    endtask

    task automatic wait_for_v1(output logic found);
        found = 1'b0;
        for (int n = 0; n < word_len + 2 && !found; n++) begin
            @(negedge sim_clk);
            found = dut.v1;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else begin
            $display("ERR %0t: %s is %b, model expects %b", $time, name, got, exp);
            errors++;
        end
        checks++;
    endtask

    task automatic reset_model();
        {m_v1, m_w2, m_x1, m_y7, m_z2} = '0;
        {n_din9, n_din10, n_din23, n_din24, n_cr13, n_cr14} = '1;
        {n_gc13, n_gc14, n_dis7, n_dis8, n_ssfb1, n_ts9, n_ts10} = '1;
        ts9_d = 1'b0;
        ts10_d = 1'b0;
        m_ml13 = 1'b0;
        m_ml14 = 1'b0;
        m_ml13_n = 1'b1;
        m_ml14_n = 1'b1;
        edge_cnt = 0;
    endtask

    // one clock of the slice with all terms taken from the values before the edge.
    task automatic step_model();
        logic s13, s14, c13, c14;
        sd_pkg::sd_phase_t ph;
        int p;
        s13 = (m_y7 & n_din9 & pbg2v & diad) | (m_y7 & ~g6dv & c4rdn & paav & g5dvn)
            | (m_x1 & n_cr13 & icsd & pcg2v & crcav) | (m_x1 & n_gc13 & crcav & pcg2v & icsdn)
            | (m_x1 & n_din23 & diad & pcg2v) | (m_w2 & n_dis7 & pcg2v & disa)
            | (m_w2 & pcg2v & n_ts9 & tsa) | (m_v1 & m_ml13_n);
        s14 = (m_y7 & n_din10 & pbg2v & diad) | (m_y7 & ~g7dv & c4rdn & paav & g6dvn)
            | (m_y7 & n_ssfb1 & ssa & pbg2v)
            | (m_x1 & n_cr14 & icsd & pcg2v & crcav) | (m_x1 & n_gc14 & crcav & pcg2v & icsdn)
            | (m_x1 & n_din24 & diad & pcg2v) | (m_w2 & n_dis8 & pcg2v & disa)
            | (m_w2 & pcg2v & n_ts10 & tsa) | (m_v1 & m_ml14_n);
        c13 = (m_v1 & m_ml13) | (m_z2 & resmv & mlav);
        c14 = (m_v1 & m_ml14) | (m_z2 & resmv & mlav);
        m_ml13 = ~s13;
        m_ml13_n = ~c13;
        m_ml14 = ~s14;
        m_ml14_n = ~c14;
        {n_din9, n_din10, n_din23, n_din24} = ~{din9, din10, din23, din24};
        {n_cr13, n_cr14, n_gc13, n_gc14} = ~{cr13, cr14, gc13, gc14};
        {n_dis7, n_dis8, n_ssfb1} = ~{dis7, dis8, ssfb1};
        // timing strobes see the level from two edges back.
        n_ts9 = ~ts9_d;
        n_ts10 = ~ts10_d;
        ts9_d = ts9;
        ts10_d = ts10;
        p = edge_cnt % word_len;
        ph = (p < sd_pkg::phase_count) ? sd_pkg::sd_phase_t'(p) : sd_pkg::ph_idle;
        m_v1 = (ph == sd_pkg::ph_v1);
        m_w2 = (ph == sd_pkg::ph_w2);
        m_x1 = (ph == sd_pkg::ph_x1);
        m_y7 = (ph == sd_pkg::ph_y7);
        m_z2 = (ph == sd_pkg::ph_z2);
        edge_cnt++;
    endtask

    always @(posedge sim_clk) begin
        if (model_valid) begin
            check_bit("ml13", ml13, m_ml13);
            check_bit("ml14", ml14, m_ml14);
            check_bit("ml13_n", dut.u_slice.ml13_n, m_ml13_n);
            check_bit("ml14_n", dut.u_slice.ml14_n, m_ml14_n);
        end
        if (rst) begin
            reset_model();
            model_valid = 1'b1;
        end else begin
            step_model();
        end
    end

    initial begin
        logic        found;
        logic [31:0] bits;
        logic [12:0] lo;
        int          hold;
        errors = 0;
        checks = 0;
        timeouts = 0;
        total_cycles = 0;
        model_valid = 1'b0;
        lfsr_state = 16'd2765;
        rst = 1'b1;
        drive_row(13'h1fff, 17'h0);
        repeat (3) @(negedge sim_clk);
        rst = 1'b0;

        // lo columns din9 din10 din23 din24 _ cr13 cr14 _ gc13 gc14 _ dis7 dis8 _ ssfb1 ts9 ts10
        // en columns c4rdn crcav diad disa _ g5dvn g6dv g6dvn g7dv _ icsd icsdn mlav paav
        //     _ pbg2v pcg2v resmv ssa _ tsa
        add_row(10, 13'b1111_11_11_11_111, 17'b0000_0000_0000_0000_0);
        add_row(8,  13'b1101_11_11_11_111, 17'b0010_0000_0000_0100_0);
        add_row(8,  13'b1110_11_11_11_111, 17'b0010_0000_0000_0100_0);
        add_row(8,  13'b1111_00_11_11_111, 17'b0100_0000_1000_0100_0);
        add_row(8,  13'b1111_11_00_11_111, 17'b0100_0000_0100_0100_0);
        add_row(8,  13'b1111_11_11_00_111, 17'b0001_0000_0000_0100_0);
        add_row(10, 13'b1111_11_11_11_100, 17'b0000_0000_0000_0100_1);
        add_row(8,  13'b1111_11_11_11_101, 17'b0000_0000_0000_0100_1);
        add_row(8,  13'b1111_11_11_11_011, 17'b0000_0000_0000_1001_0);
        add_row(8,  13'b1111_11_11_11_111, 17'b1000_0110_0001_0000_0);
        add_row(8,  13'b1111_11_11_11_111, 17'b1000_1000_0001_0000_0);
        add_row(8,  13'b0011_11_11_11_111, 17'b0010_0000_0000_1000_0);
        add_row(16, 13'b1111_11_11_11_111, 17'b0000_0000_0010_0010_0);
        add_row(14, 13'b1100_11_11_11_111, 17'b0010_0000_0010_0110_0);
        add_row(14, 13'b1111_11_11_11_111, 17'b0000_0000_0000_0000_0);
        n_directed = row_hold.size();

        total_cycles = 0;
        while (total_cycles < 220) begin
            take_bits(3, bits);
            hold = 2 + int'(bits[2:0]);
            take_bits(13, bits);
            lo = bits[12:0];
            take_bits(17, bits);
            add_row(hold, lo, bits[16:0]);
        end

        // directed rows start on a v1 word boundary while random rows run back to back.
        for (int r = 0; r < row_hold.size(); r++) begin
            if (r < n_directed) begin
                wait_for_v1(found);
                if (!found) begin
                    $display("timeout: no v1 phase pulse seen before table row %0d", r);
                    timeouts++;
                end
            end
            drive_row(row_lo[r], row_en[r]);
            repeat (row_hold[r]) @(negedge sim_clk);
        end
        repeat (2) @(negedge sim_clk);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: files.f
hdl/sd_pkg.sv
hdl/sd_gates.sv
hdl/sd_timing_gen.sv
hdl/sd_sampler_7.sv
hdl/sd_sampler.sv
tb/sd_sampler_tb.sv
